// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pipeline -f sim.f -o tb_pipeline

sim_out=$(./obj_dir/tb_pipeline 2>&1) || true
echo "$sim_out"
echo "$sim_out" | grep -qx "TESTS PASSED"

// File: sim.f
verilog/pipe_pkg.sv
verilog/wb_if.sv
verilog/pipe_latch.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/operand_stage.sv
verilog/execute_stage.sv
verilog/pipeline.sv
tests/pipeline_properties.sv
tests/tb_pipeline.sv

// File: tests/pipeline_properties.sv
`timescale 1ns/1ps

module pipeline_properties (
   input logic                          clk,
   input logic                          rst_n,
   input logic                          instr_valid,
   input logic [pipe_pkg::instr_w-1:0]  instr,
   input logic                          instr_ready,
   input logic                          wb_valid,
   input logic [pipe_pkg::reg_id_w-1:0] wb_dr
);

   logic                          accept;
   logic                          seen_accept;
   logic                          accept_d1;
   logic                          accept_d2;
   logic                          ready_d1;
   logic [pipe_pkg::reg_id_w-1:0] dr_d1;
   logic [pipe_pkg::reg_id_w-1:0] dr_d2;
   logic                          raw_d1;
   logic                          raw_d2;

   // sr1 is always a source, sr2 only without an immediate
   function automatic logic reads_reg(input logic [pipe_pkg::instr_w-1:0]  word,
                                      input logic [pipe_pkg::reg_id_w-1:0] id);
      return (word[pipe_pkg::sr1_msb:pipe_pkg::sr1_lsb] == id) ||
             (!word[pipe_pkg::use_imm_bit] &&
              (word[pipe_pkg::sr2_msb:pipe_pkg::sr2_lsb] == id));
   endfunction

   assign accept = instr_valid && instr_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         seen_accept <= 1'b0;
         accept_d1   <= 1'b0;
         accept_d2   <= 1'b0;
         ready_d1    <= 1'b0;
      end else begin
         if (accept) begin
            seen_accept <= 1'b1;
         end
         accept_d1 <= accept;
         accept_d2 <= accept_d1;
         ready_d1  <= instr_ready;
      end
   end

   always_ff @(posedge clk) begin
      dr_d1 <= instr[pipe_pkg::dr_msb:pipe_pkg::dr_lsb];
      dr_d2 <= dr_d1;
   end

   // Reads a result still in execute or in writeback
   assign raw_d1 = accept && accept_d1 && reads_reg(instr, dr_d1);
   assign raw_d2 = accept && accept_d2 && ready_d1 && reads_reg(instr, dr_d2);

   a_idle_after_reset: assert property (
      @(posedge clk) disable iff (!rst_n)
      !seen_accept |-> (!wb_valid && instr_ready)
   ) else $error("Pipeline not idle before the first accepted instruction");

   a_raw_stalls: assert property (
      @(posedge clk) disable iff (!rst_n)
      (raw_d1 || raw_d2) |=> !instr_ready
   ) else $error("instr_ready stayed high for a dependent instruction");

   // Accepted, then not stalled in the operand stage
   a_three_edges: assert property (
      @(posedge clk) disable iff (!rst_n)
      ($past(rst_n, 3) && $past(accept, 3) && $past(instr_ready, 2))
      |-> (wb_valid && (wb_dr == $past(instr[pipe_pkg::dr_msb:pipe_pkg::dr_lsb], 3)))
   ) else $error("Result did not retire three edges after acceptance");

endmodule

bind pipeline pipeline_properties u_properties (
   .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
   .instr_ready(instr_ready), .wb_valid(wb_valid), .wb_dr(wb_dr)
);

// File: tests/tb_pipeline.sv
`timescale 1ns/1ps

module tb_pipeline;

   localparam int num_instr    = 200;
   localparam int sweep_start  = 40;
   localparam int clk_period   = 100;
   localparam int drive_delay  = 5;
   localparam int reset_cycles = 10;
   localparam int max_cycles   = num_instr * 6 + 100;
   localparam int unsigned rand_seed = 32'ha148;

   logic                          clk;
   logic                          rst_n;
   logic                          instr_valid;
   logic [pipe_pkg::instr_w-1:0]  instr;
   logic                          instr_ready;
   logic                          wb_valid;
   logic [pipe_pkg::reg_id_w-1:0] wb_dr;
   logic [pipe_pkg::data_w-1:0]   wb_data;

   logic [pipe_pkg::instr_w-1:0]  in_flight [$];
   logic [pipe_pkg::data_w-1:0]   model_gpr [pipe_pkg::num_gprs];
   int                            retired;
   int                            cycles;

   pipeline dut (
      .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
      .instr_ready(instr_ready), .wb_valid(wb_valid), .wb_dr(wb_dr), .wb_data(wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   // Mostly r0..r2 so that back-to-back dependencies are common
   function automatic logic [pipe_pkg::reg_id_w-1:0] pick_reg();
      if ($urandom_range(0, 3) != 0) begin
         return 3'($urandom_range(0, 2));
      end
      return 3'($urandom_range(0, 7));
   endfunction

   function automatic logic [pipe_pkg::instr_w-1:0] make_instr(input int idx);
      logic [pipe_pkg::instr_w-1:0] word;
      logic [2:0]                   aluk;
      logic                         use_imm;
      word = '0;
      // A short sweep covers every op with both kinds of operand b
      if (idx >= sweep_start && idx < sweep_start + 16) begin
         aluk    = 3'(idx - sweep_start);
         use_imm = (idx - sweep_start) >= 8;
      end else begin
         aluk    = 3'($urandom_range(0, 7));
         use_imm = 1'($urandom_range(0, 1));
      end
      word[pipe_pkg::aluk_msb:pipe_pkg::aluk_lsb] = aluk;
      word[pipe_pkg::dr_msb:pipe_pkg::dr_lsb]     = pick_reg();
      word[pipe_pkg::sr1_msb:pipe_pkg::sr1_lsb]   = pick_reg();
      word[pipe_pkg::sr2_msb:pipe_pkg::sr2_lsb]   = pick_reg();
      word[pipe_pkg::use_imm_bit]                 = use_imm;
      word[pipe_pkg::imm_msb:pipe_pkg::imm_lsb]   = 16'($urandom);
      return word;
   endfunction

   function automatic logic [pipe_pkg::data_w-1:0] expected_result(
      input logic [pipe_pkg::instr_w-1:0] word);
      logic [pipe_pkg::data_w-1:0] a;
      logic [pipe_pkg::data_w-1:0] b;
      logic [4:0]                  shamt;
      a = model_gpr[word[pipe_pkg::sr1_msb:pipe_pkg::sr1_lsb]];
      if (word[pipe_pkg::use_imm_bit]) begin
         b = {16'b0, word[pipe_pkg::imm_msb:pipe_pkg::imm_lsb]};
      end else begin
         b = model_gpr[word[pipe_pkg::sr2_msb:pipe_pkg::sr2_lsb]];
      end
      shamt = b[4:0];
      case (word[pipe_pkg::aluk_msb:pipe_pkg::aluk_lsb])
         pipe_pkg::aluk_add: return a + b;
         pipe_pkg::aluk_sub: return a - b;
         pipe_pkg::aluk_and: return a & b;
         pipe_pkg::aluk_or:  return a | b;
         pipe_pkg::aluk_xor: return a ^ b;
         pipe_pkg::aluk_shl: return a << shamt;
         pipe_pkg::aluk_shr: return a >> shamt;
         default:            return b;
      endcase
   endfunction

   task automatic check_retire();
      logic [pipe_pkg::instr_w-1:0]  word;
      logic [pipe_pkg::reg_id_w-1:0] exp_dr;
      logic [pipe_pkg::data_w-1:0]   exp_data;
      assert (in_flight.size() > 0) else
         stop_on_error($sformatf("Writeback at %0t with no instruction in flight", $time));
      word     = in_flight.pop_front();
      exp_dr   = word[pipe_pkg::dr_msb:pipe_pkg::dr_lsb];
      exp_data = expected_result(word);
      assert (wb_dr == exp_dr) else
         stop_on_error($sformatf("MISMATCH at %0t: wb_dr %0d, expected %0d",
                                 $time, wb_dr, exp_dr));
      assert (wb_data == exp_data) else
         stop_on_error($sformatf("MISMATCH at %0t: wb_data %h for r%0d, expected %h",
                                 $time, wb_data, exp_dr, exp_data));
      model_gpr[exp_dr] = exp_data;
      retired++;
   endtask

   // Outputs are stable at the falling edge, acceptance happens at the next rising one
   always @(negedge clk) begin
      if (rst_n) begin
         if (wb_valid) begin
            check_retire();
         end
         if (instr_valid && instr_ready) begin
            in_flight.push_back(instr);
         end
      end
   end

   task automatic send_instr(input logic [pipe_pkg::instr_w-1:0] word);
      logic taken;
      instr_valid = 1'b1;
      instr       = word;
      taken       = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = instr_ready;
         @(posedge clk);
         #drive_delay;
      end
   endtask

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", max_cycles));
   end

   initial begin
      void'($urandom(rand_seed));
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      retired     = 0;
      for (int r = 0; r < pipe_pkg::num_gprs; r++) begin
         model_gpr[r] = '0;
      end
      repeat (reset_cycles) @(posedge clk);
      #drive_delay;
      rst_n = 1'b1;

      for (int i = 0; i < num_instr; i++) begin
         // Occasional idle cycle
         if ($urandom_range(0, 4) == 0) begin
            instr_valid = 1'b0;
            @(posedge clk);
            #drive_delay;
         end
         send_instr(make_instr(i));
      end
      instr_valid = 1'b0;

      while (in_flight.size() > 0) begin
         @(negedge clk);
      end
      // A few more cycles to catch any stray writeback
      repeat (4) @(negedge clk);

      if (retired == num_instr) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         stop_on_error($sformatf("Only %0d of %0d instructions retired", retired, num_instr));
      end
   end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic [pipe_pkg::instr_w-1:0] instr,
   output pipe_pkg::de_t                de
);

   always_comb begin
      de.aluk    = pipe_pkg::aluk_e'(instr[pipe_pkg::aluk_msb:pipe_pkg::aluk_lsb]);
      de.dr      = instr[pipe_pkg::dr_msb:pipe_pkg::dr_lsb];
      de.sr1     = instr[pipe_pkg::sr1_msb:pipe_pkg::sr1_lsb];
      de.sr2     = instr[pipe_pkg::sr2_msb:pipe_pkg::sr2_lsb];
      de.use_imm = instr[pipe_pkg::use_imm_bit];
      // Immediate is zero extended
      de.imm     = {{(pipe_pkg::data_w - pipe_pkg::imm_w){1'b0}},
                    instr[pipe_pkg::imm_msb:pipe_pkg::imm_lsb]};
      // Every op reads operand b, so sr2 is read unless the immediate replaces it
      de.sr2_needed = !de.use_imm;
   end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
   input  pipe_pkg::ex_t ex,
   output pipe_pkg::wb_t wb_next
);

   logic [pipe_pkg::shamt_w-1:0] shamt;

   assign shamt = ex.b[pipe_pkg::shamt_w-1:0];

   always_comb begin
      wb_next.dr     = ex.dr;
      wb_next.result = ex.b;
      case (ex.aluk)
         pipe_pkg::aluk_add: begin
            wb_next.result = ex.a + ex.b;
         end
         pipe_pkg::aluk_sub: begin
            wb_next.result = ex.a - ex.b;
         end
         pipe_pkg::aluk_and: begin
            wb_next.result = ex.a & ex.b;
         end
         pipe_pkg::aluk_or: begin
            wb_next.result = ex.a | ex.b;
         end
         pipe_pkg::aluk_xor: begin
            wb_next.result = ex.a ^ ex.b;
         end
         pipe_pkg::aluk_shl: begin
            wb_next.result = ex.a << shamt;
         end
         // Logical shift, zeros fill from the top
         pipe_pkg::aluk_shr: begin
            wb_next.result = ex.a >> shamt;
         end
         pipe_pkg::aluk_mov: begin
            wb_next.result = ex.b;
         end
         default: begin
            wb_next.result = ex.b;
         end
      endcase
   end

endmodule

// File: verilog/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
   input  logic                          de_valid,
   input  pipe_pkg::de_t                 de,
   input  logic                          ex_valid,
   input  logic [pipe_pkg::reg_id_w-1:0] ex_dr,
   input  logic [pipe_pkg::data_w-1:0]   rd_data1,
   input  logic [pipe_pkg::data_w-1:0]   rd_data2,
   wb_if.watch                           wb,
   output logic [pipe_pkg::reg_id_w-1:0] rd_id1,
   output logic [pipe_pkg::reg_id_w-1:0] rd_id2,
   output pipe_pkg::ex_t                 ex_next,
   output logic                          stall
);

   logic wb_writes;
   logic sr1_hit;
   logic sr2_hit;

   assign rd_id1 = de.sr1;
   assign rd_id2 = de.sr2;

   // Operand b is either the immediate or the second source
   always_comb begin
      ex_next.aluk = de.aluk;
      ex_next.dr   = de.dr;
      ex_next.a    = rd_data1;
      ex_next.b    = de.use_imm ? de.imm : rd_data2;
   end

   // Every valid execute entry writes its dr
   assign wb_writes = wb.valid && wb.ld_gpr;

   assign sr1_hit = (ex_valid && (ex_dr == de.sr1)) ||
                    (wb_writes && (wb.dr == de.sr1));
   assign sr2_hit = (ex_valid && (ex_dr == de.sr2)) ||
                    (wb_writes && (wb.dr == de.sr2));

   // Wait until older writers have left writeback
   assign stall = de_valid && (sr1_hit || (de.sr2_needed && sr2_hit));

endmodule

// File: verilog/pipe_latch.sv
`timescale 1ns/1ps

module pipe_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     hold,
   input  logic     bubble,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   // Valid bit, hold wins over bubble
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (hold) begin
         out_valid <= out_valid;
      end else if (bubble) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   // Payload only meaningful while out_valid is set
   always_ff @(posedge clk) begin
      if (!hold) begin
         out_data <= in_data;
      end
   end

endmodule

// File: verilog/pipe_pkg.sv
package pipe_pkg;

   // Datapath and register file sizes
   localparam int data_w   = 32;
   localparam int reg_id_w = 3;
   localparam int num_gprs = 8;
   localparam int instr_w  = 32;

   // Instruction word layout
   localparam int aluk_msb    = 31;
   localparam int aluk_lsb    = 29;
   localparam int dr_msb      = 28;
   localparam int dr_lsb      = 26;
   localparam int sr1_msb     = 25;
   localparam int sr1_lsb     = 23;
   localparam int sr2_msb     = 22;
   localparam int sr2_lsb     = 20;
   localparam int use_imm_bit = 19;
   localparam int imm_msb     = 15;
   localparam int imm_lsb     = 0;
   localparam int imm_w       = imm_msb - imm_lsb + 1;

   // Shift amount taken from the low bits of operand b
   localparam int shamt_w = 5;

   typedef enum logic [2:0] {
      aluk_add,
      aluk_sub,
      aluk_and,
      aluk_or,
      aluk_xor,
      aluk_shl,
      aluk_shr,
      aluk_mov
   } aluk_e;

   typedef struct packed {
      aluk_e                aluk;
      logic [reg_id_w-1:0]  dr;
      logic [reg_id_w-1:0]  sr1;
      logic [reg_id_w-1:0]  sr2;
      logic                 use_imm;
      logic [data_w-1:0]    imm;
      logic                 sr2_needed;
   } de_t;

   typedef struct packed {
      aluk_e                aluk;
      logic [reg_id_w-1:0]  dr;
      logic [data_w-1:0]    a;
      logic [data_w-1:0]    b;
   } ex_t;

   typedef struct packed {
      logic [reg_id_w-1:0]  dr;
      logic [data_w-1:0]    result;
   } wb_t;

endpackage

// File: verilog/pipeline.sv
`timescale 1ns/1ps

module pipeline (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          instr_valid,
   input  logic [pipe_pkg::instr_w-1:0]  instr,
   output logic                          instr_ready,
   output logic                          wb_valid,
   output logic [pipe_pkg::reg_id_w-1:0] wb_dr,
   output logic [pipe_pkg::data_w-1:0]   wb_data
);

   pipe_pkg::de_t                 de_next;
   pipe_pkg::de_t                 de_q;
   logic                          de_valid;
   pipe_pkg::ex_t                 ex_next;
   pipe_pkg::ex_t                 ex_q;
   logic                          ex_valid;
   pipe_pkg::wb_t                 wb_next;
   pipe_pkg::wb_t                 wb_q;
   logic                          stall;
   logic [pipe_pkg::reg_id_w-1:0] rd_id1;
   logic [pipe_pkg::reg_id_w-1:0] rd_id2;
   logic [pipe_pkg::data_w-1:0]   rd_data1;
   logic [pipe_pkg::data_w-1:0]   rd_data2;

   wb_if wb_bus ();

   decode_stage u_decode_stage (.instr(instr), .de(de_next));

   // Decode latch holds its instruction during a stall
   pipe_latch #(.payload_t(pipe_pkg::de_t)) u_de_latch (
      .clk(clk), .rst_n(rst_n), .hold(stall), .bubble(1'b0),
      .in_valid(instr_valid), .in_data(de_next),
      .out_valid(de_valid), .out_data(de_q)
   );

   operand_stage u_operand_stage (
      .de_valid(de_valid), .de(de_q), .ex_valid(ex_valid), .ex_dr(ex_q.dr),
      .rd_data1(rd_data1), .rd_data2(rd_data2), .wb(wb_bus.watch),
      .rd_id1(rd_id1), .rd_id2(rd_id2), .ex_next(ex_next), .stall(stall)
   );

   register_file u_register_file (
      .clk(clk), .rst_n(rst_n), .rd_id1(rd_id1), .rd_id2(rd_id2),
      .rd_data1(rd_data1), .rd_data2(rd_data2), .wb(wb_bus.sink)
   );

   // Bubble into execute while the operand stage waits
   pipe_latch #(.payload_t(pipe_pkg::ex_t)) u_ex_latch (
      .clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(stall),
      .in_valid(de_valid), .in_data(ex_next),
      .out_valid(ex_valid), .out_data(ex_q)
   );

   execute_stage u_execute_stage (.ex(ex_q), .wb_next(wb_next));

   pipe_latch #(.payload_t(pipe_pkg::wb_t)) u_wb_latch (
      .clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(1'b0),
      .in_valid(ex_valid), .in_data(wb_next),
      .out_valid(wb_valid), .out_data(wb_q)
   );

   assign wb_bus.valid  = wb_valid;
   assign wb_bus.dr     = wb_q.dr;
   assign wb_bus.data   = wb_q.result;
   assign wb_bus.ld_gpr = wb_valid;

   assign instr_ready = !stall;
   assign wb_dr       = wb_q.dr;
   assign wb_data     = wb_q.result;

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [pipe_pkg::reg_id_w-1:0] rd_id1,
   input  logic [pipe_pkg::reg_id_w-1:0] rd_id2,
   output logic [pipe_pkg::data_w-1:0]   rd_data1,
   output logic [pipe_pkg::data_w-1:0]   rd_data2,
   wb_if.sink                            wb
);

   logic [pipe_pkg::data_w-1:0] gpr [pipe_pkg::num_gprs];

   // Single write port driven by writeback
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < pipe_pkg::num_gprs; i++) begin
            gpr[i] <= '0;
         end
      end else if (wb.valid && wb.ld_gpr) begin
         gpr[wb.dr] <= wb.data;
      end
   end

   // No write-through, the stall covers a pending write
   assign rd_data1 = gpr[rd_id1];
   assign rd_data2 = gpr[rd_id2];

endmodule

// File: verilog/wb_if.sv
`timescale 1ns/1ps

interface wb_if;
   logic                          valid;
   logic [pipe_pkg::reg_id_w-1:0] dr;
   logic [pipe_pkg::data_w-1:0]   data;
   // Every current op writes a GPR, kept for future non-writing ops
   logic                          ld_gpr;

   modport source (output valid, output dr, output data, output ld_gpr);

   modport sink (input valid, input dr, input data, input ld_gpr);

   // Dependency check only needs the destination, not the data
   modport watch (input valid, input dr, input ld_gpr);
endinterface
